//--- rtl/bubblePkg.sv
package bubblePkg;

    // Buffer holds 2048 two-bit words
    parameter int AddrWidth = 11;

    // Tick counter, all ones while no transfer runs
    parameter int CountWidth = 14;

    // Codes follow {pageSelect, coilEnable, positionLatch}
    typedef enum logic [2:0]
    {
        bootloaderAccess = 3'b000,
        initialStandby   = 3'b010,
        normalAccess     = 3'b100,
        pageLatch        = 3'b101,
        normalStandby    = 3'b110
    } accessState_t;

    // Work done by the sequencer on the clock after a tick
    typedef enum logic [1:0]
    {
        stepIdle    = 2'b00,
        stepAdvance = 2'b01, // Move read address
        stepRead    = 2'b10  // Fetch word at read address
    } seqStep_t;

    // Count at which the first data pair appears
    parameter int DefaultPageStart = 201;
    parameter int DefaultBootStart = 5285;

    // Data counts per transfer, two per buffer word
    parameter int DefaultPageWindow = 1024;
    parameter int DefaultBootWindow = 3840;

    // Low counts after the bootloader data
    parameter int DefaultBootTail = 12;

endpackage

//--- rtl/bubbleAccessFsm.sv
`timescale 1ns/100ps

module bubbleAccessFsm
(
    input  logic bubble_buffer_write_clock,
    input  logic arstN,
    input  logic pageSelect,
    input  logic coilEnable,    // Coil run, active low
    input  logic positionLatch,
    output logic loadBootloader, // Active low
    output logic loadPage        // Active low
);

    bubblePkg::accessState_t state;
    bubblePkg::accessState_t nextState;
    logic                    nextBootloader;
    logic                    nextPage;
    logic [2:0]              accessCode;

    assign accessCode = {pageSelect, coilEnable, positionLatch};

    // Anything not accepted below keeps state and enables
    always_comb
    begin
        nextState      = state;
        nextBootloader = loadBootloader;
        nextPage       = loadPage;
        case (accessCode)
            bubblePkg::bootloaderAccess:
            begin
                // No way back to the bootloader once pages run
                if (state != bubblePkg::normalAccess && state != bubblePkg::pageLatch)
                begin
                    nextState      = bubblePkg::bootloaderAccess;
                    nextBootloader = 1'b0;
                    nextPage       = 1'b1;
                end
            end
            bubblePkg::initialStandby:
            begin
                if (state != bubblePkg::pageLatch) // Latch to standby is a glitch
                begin
                    nextState      = bubblePkg::initialStandby;
                    nextBootloader = 1'b1;
                    nextPage       = 1'b1;
                end
            end
            bubblePkg::normalAccess:
            begin
                nextState = bubblePkg::normalAccess; // Enables stay as they are
            end
            bubblePkg::pageLatch:
            begin
                if (state == bubblePkg::normalAccess) // Only entry into the latch
                begin
                    nextState      = bubblePkg::pageLatch;
                    nextBootloader = 1'b1;
                    nextPage       = 1'b0;
                end
            end
            bubblePkg::normalStandby:
            begin
                if (state != bubblePkg::pageLatch)
                begin
                    nextState      = bubblePkg::normalStandby;
                    nextBootloader = 1'b1;
                    nextPage       = 1'b1;
                end
            end
            default:
            begin
                nextState = state; // Undefined input combination
            end
        endcase
    end

    always_ff @(posedge bubble_buffer_write_clock or negedge arstN)
    begin
        if (!arstN)
        begin
            state          <= bubblePkg::initialStandby;
            loadBootloader <= 1'b1;
            loadPage       <= 1'b1;
        end
        else
        begin
            state          <= nextState;
            loadBootloader <= nextBootloader;
            loadPage       <= nextPage;
        end
    end

endmodule

//--- rtl/bubbleBuffer.sv
`timescale 1ns/100ps

module bubbleBuffer
(
    input  logic                           bubble_buffer_write_clock,
    input  logic                           arstN,
    input  logic                           pSel,
    input  logic                           pEnable,
    input  logic                           pWrite,
    input  logic [bubblePkg::AddrWidth-1:0] pAddr,
    input  logic [1:0]                     pWData,
    input  logic                           readEn,
    input  logic [bubblePkg::AddrWidth-1:0] readAddr,
    output logic                           pReady,
    output logic                           pSlvErr,
    output logic [1:0]                     readData
);

    localparam int Depth = 1 << bubblePkg::AddrWidth;

    logic [1:0] bufferMem [0:Depth-1];
    logic       readPending; // Current transfer is a read
    logic       writeAccess;

    // Zero wait states
    assign pReady = 1'b1;

    assign writeAccess = pSel && pEnable && pWrite;

    // Transfer direction is decoded in the setup phase
    always_ff @(posedge bubble_buffer_write_clock or negedge arstN)
    begin
        if (!arstN)
        begin
            readPending <= 1'b0;
        end
        else if (pSel && !pEnable)
        begin
            readPending <= !pWrite;
        end
        else if (pSel && pEnable)
        begin
            readPending <= 1'b0; // Transfer ends here
        end
    end

    // Reads are not supported
    assign pSlvErr = pSel && pEnable && readPending;

    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (writeAccess)
        begin
            bufferMem[pAddr] <= pWData;
        end
    end

    // Sequencer port, data one clock after the request
    always_ff @(posedge bubble_buffer_write_clock)
    begin
        if (readEn)
        begin
            readData <= bufferMem[readAddr];
        end
    end

endmodule

//--- rtl/bubbleOutSequencer.sv
`timescale 1ns/100ps

module bubbleOutSequencer
#(
    parameter int PageStart  = bubblePkg::DefaultPageStart,
    parameter int BootStart  = bubblePkg::DefaultBootStart,
    parameter int PageWindow = bubblePkg::DefaultPageWindow,
    parameter int BootWindow = bubblePkg::DefaultBootWindow
)
(
    input  logic                             bubble_buffer_write_clock,
    input  logic                             arstN,
    input  logic                             dataOutTick,
    input  logic                             loadBootloader,
    input  logic                             loadPage,
    output logic [bubblePkg::CountWidth-1:0] tickCount,
    output logic [bubblePkg::AddrWidth-1:0]  readAddr,
    output logic                             readEn
);

    localparam int CountWidth = bubblePkg::CountWidth;

    // Offsets before the data window, modulo the counter width
    localparam logic [CountWidth-1:0] OffsetAddrClear = {CountWidth{1'b1}} - 3; // Start - 4
    localparam logic [CountWidth-1:0] OffsetFirstRead = {CountWidth{1'b1}} - 2; // Start - 3
    localparam logic [CountWidth-1:0] OffsetLastRead  = {CountWidth{1'b1}};     // Start - 1

    logic                   counterStop;
    logic                   transferActive;
    logic                   tickSeen;    // Count changed on the last edge
    logic [CountWidth-1:0]  activeStart;
    logic [CountWidth-1:0]  activeWindow;
    logic [CountWidth-1:0]  offset;
    bubblePkg::seqStep_t    step;

    assign counterStop    = loadBootloader && loadPage;
    assign transferActive = loadBootloader ^ loadPage; // Both low counts as idle

    always_comb
    begin
        if (!loadBootloader)
        begin
            activeStart  = CountWidth'(BootStart);
            activeWindow = CountWidth'(BootWindow);
        end
        else
        begin
            activeStart  = CountWidth'(PageStart);
            activeWindow = CountWidth'(PageWindow);
        end
    end

    always_ff @(posedge bubble_buffer_write_clock or negedge arstN)
    begin
        if (!arstN)
        begin
            tickCount <= '1;
            tickSeen  <= 1'b0;
        end
        else
        begin
            tickSeen <= dataOutTick;
            if (counterStop)
            begin
                tickCount <= '1;
            end
            else if (dataOutTick)
            begin
                tickCount <= tickCount + 1'b1; // All ones wraps to zero
            end
        end
    end

    // Distance from the first data count
    assign offset = tickCount - activeStart;

    always_comb
    begin
        step = bubblePkg::stepIdle;
        if (tickSeen && transferActive)
        begin
            if (offset == OffsetAddrClear)
            begin
                step = bubblePkg::stepAdvance;
            end
            else if (offset == OffsetFirstRead || offset == OffsetLastRead)
            begin
                step = bubblePkg::stepRead;
            end
            else if (offset < activeWindow)
            begin
                // Read on the first count of a pair, advance on the second
                step = offset[0] ? bubblePkg::stepAdvance : bubblePkg::stepRead;
            end
        end
    end

    assign readEn = (step == bubblePkg::stepRead);

    always_ff @(posedge bubble_buffer_write_clock or negedge arstN)
    begin
        if (!arstN)
        begin
            readAddr <= '1;
        end
        else if (!transferActive)
        begin
            readAddr <= '1;
        end
        else if (step == bubblePkg::stepAdvance)
        begin
            readAddr <= (offset == OffsetAddrClear) ? '0 : readAddr + 1'b1;
        end
    end

endmodule

//--- rtl/bubbleOutputMux.sv
`timescale 1ns/100ps

module bubbleOutputMux
#(
    parameter int PageStart  = bubblePkg::DefaultPageStart,
    parameter int BootStart  = bubblePkg::DefaultBootStart,
    parameter int PageWindow = bubblePkg::DefaultPageWindow,
    parameter int BootWindow = bubblePkg::DefaultBootWindow,
    parameter int BootTail   = bubblePkg::DefaultBootTail
)
(
    input  logic                             moduleEnable, // Active low
    input  logic                             loadBootloader,
    input  logic                             loadPage,
    input  logic [bubblePkg::CountWidth-1:0] tickCount,
    input  logic [1:0]                       readData,
    output logic                             bubbleOutOdd,
    output logic                             bubbleOutEven
);

    localparam int CountWidth = bubblePkg::CountWidth;

    logic [CountWidth-1:0] bootOffset;
    logic [CountWidth-1:0] pageOffset;

    assign bootOffset = tickCount - CountWidth'(BootStart);
    assign pageOffset = tickCount - CountWidth'(PageStart);

    always_comb
    begin
        {bubbleOutOdd, bubbleOutEven} = 2'b11; // Idle level
        if (moduleEnable)
        begin
            {bubbleOutOdd, bubbleOutEven} = 2'b00;
        end
        else if (!loadBootloader && loadPage)
        begin
            if (bootOffset == {CountWidth{1'b1}} - 3 || bootOffset == {CountWidth{1'b1}} - 2)
            begin
                {bubbleOutOdd, bubbleOutEven} = 2'b10; // Preamble start
            end
            else if (bootOffset >= {CountWidth{1'b1}} - 1)
            begin
                {bubbleOutOdd, bubbleOutEven} = 2'b00;
            end
            else if (bootOffset < CountWidth'(BootWindow))
            begin
                {bubbleOutOdd, bubbleOutEven} = ~readData;
            end
            else if (bootOffset < CountWidth'(BootWindow + BootTail))
            begin
                {bubbleOutOdd, bubbleOutEven} = 2'b00; // Tail
            end
        end
        else if (loadBootloader && !loadPage)
        begin
            if (pageOffset < CountWidth'(PageWindow))
            begin
                {bubbleOutOdd, bubbleOutEven} = ~readData;
            end
        end
    end

endmodule

//--- rtl/bubbleInterface.sv
`timescale 1ns/100ps

module bubbleInterface
#(
    parameter int PageStart  = bubblePkg::DefaultPageStart,
    parameter int BootStart  = bubblePkg::DefaultBootStart,
    parameter int PageWindow = bubblePkg::DefaultPageWindow,
    parameter int BootWindow = bubblePkg::DefaultBootWindow,
    parameter int BootTail   = bubblePkg::DefaultBootTail
)
(
    input  logic                            bubble_buffer_write_clock,
    input  logic                            arstN,
    input  logic                            pSel,
    input  logic                            pEnable,
    input  logic                            pWrite,
    input  logic [bubblePkg::AddrWidth-1:0] pAddr,
    input  logic [1:0]                      pWData,
    output logic                            pReady,
    output logic                            pSlvErr,
    input  logic                            pageSelect,
    input  logic                            coilEnable,    // Active low
    input  logic                            positionLatch,
    input  logic                            dataOutTick,   // One clock per data-out strobe
    input  logic                            moduleEnable,  // Active low
    output logic                            loadBootloader,
    output logic                            loadPage,
    output logic                            bubbleOutOdd,
    output logic                            bubbleOutEven
);

    logic [bubblePkg::CountWidth-1:0] tickCount;
    logic [bubblePkg::AddrWidth-1:0]  readAddr;
    logic                             readEn;
    logic [1:0]                       readData;

    bubbleAccessFsm accessFsm0
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .arstN                     (arstN),
        .pageSelect                (pageSelect),
        .coilEnable                (coilEnable),
        .positionLatch             (positionLatch),
        .loadBootloader            (loadBootloader),
        .loadPage                  (loadPage)
    );

    bubbleBuffer buffer0
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .arstN                     (arstN),
        .pSel                      (pSel),
        .pEnable                   (pEnable),
        .pWrite                    (pWrite),
        .pAddr                     (pAddr),
        .pWData                    (pWData),
        .readEn                    (readEn),
        .readAddr                  (readAddr),
        .pReady                    (pReady),
        .pSlvErr                   (pSlvErr),
        .readData                  (readData)
    );

    bubbleOutSequencer
    #(
        .PageStart  (PageStart),
        .BootStart  (BootStart),
        .PageWindow (PageWindow),
        .BootWindow (BootWindow)
    ) sequencer0
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .arstN                     (arstN),
        .dataOutTick               (dataOutTick),
        .loadBootloader            (loadBootloader),
        .loadPage                  (loadPage),
        .tickCount                 (tickCount),
        .readAddr                  (readAddr),
        .readEn                    (readEn)
    );

    bubbleOutputMux
    #(
        .PageStart  (PageStart),
        .BootStart  (BootStart),
        .PageWindow (PageWindow),
        .BootWindow (BootWindow),
        .BootTail   (BootTail)
    ) outputMux0
    (
        .moduleEnable   (moduleEnable),
        .loadBootloader (loadBootloader),
        .loadPage       (loadPage),
        .tickCount      (tickCount),
        .readData       (readData),
        .bubbleOutOdd   (bubbleOutOdd),
        .bubbleOutEven  (bubbleOutEven)
    );

endmodule

//--- test/bubbleInterfaceTests.svh
// Output pair for a tick count, built from the transfer geometry
function automatic logic [1:0] expectedPair(input int count, input logic bootOn,
                                            input logic pageOn, input logic disabled);
    logic [1:0] pair;
    pair = 2'b11; // Idle level
    if (disabled)
    begin
        pair = 2'b00;
    end
    else if (bootOn && !pageOn)
    begin
        if (count >= BootStart - 4 && count <= BootStart - 3)
            pair = 2'b10;
        else if (count >= BootStart - 2 && count < BootStart)
            pair = 2'b00;
        else if (count >= BootStart && count < BootStart + BootWindow)
            pair = ~modelMem[(count - BootStart) / 2]; // Two counts per word
        else if (count >= BootStart + BootWindow && count < BootStart + BootWindow + BootTail)
            pair = 2'b00;
    end
    else if (pageOn && !bootOn)
    begin
        if (count >= PageStart && count < PageStart + PageWindow)
            pair = ~modelMem[(count - PageStart) / 2];
    end
    return pair;
endfunction

task automatic apbWrite(input int addr, input logic [1:0] data);
    pSel    = 1'b1;
    pEnable = 1'b0;
    pWrite  = 1'b1;
    pAddr   = addr[bubblePkg::AddrWidth-1:0];
    pWData  = data;
    @(negedge bubble_buffer_write_clock);
    pEnable = 1'b1; // Access phase
    #(ClockPeriod / 4); // Flags settle inside the access phase
    checkBit("pReady", pReady, 1'b1);
    checkBit("pSlvErr", pSlvErr, 1'b0);
    modelMem[addr] = data;
    @(negedge bubble_buffer_write_clock);
    pSel    = 1'b0;
    pEnable = 1'b0;
endtask

task automatic apbRead(input int addr, input logic [1:0] busData);
    pSel    = 1'b1;
    pEnable = 1'b0;
    pWrite  = 1'b0;
    pAddr   = addr[bubblePkg::AddrWidth-1:0];
    pWData  = busData; // Must not reach the buffer
    @(negedge bubble_buffer_write_clock);
    pEnable = 1'b1;
    #(ClockPeriod / 4);
    checkBit("pReady", pReady, 1'b1);
    checkBit("pSlvErr", pSlvErr, 1'b1);
    @(negedge bubble_buffer_write_clock);
    pSel    = 1'b0;
    pEnable = 1'b0;
endtask

task automatic fillRandom(input int words);
    int rnd;
    for (int addr = 0; addr < words; addr++)
    begin
        rnd = $random(seed);
        apbWrite(addr, rnd[1:0]);
    end
endtask

task automatic setAccess(input bubblePkg::accessState_t code);
    {pageSelect, coilEnable, positionLatch} = code;
    @(negedge bubble_buffer_write_clock);
endtask

// One tick, then the pair is checked once it has settled
task automatic tickAndCheck();
    dataOutTick = 1'b1;
    @(negedge bubble_buffer_write_clock);
    dataOutTick = 1'b0;
    repeat (3) @(negedge bubble_buffer_write_clock);
    expCount = (expCount + 1) % CountSpan;
    checkPair($sformatf("bubbleOutOdd,bubbleOutEven at count %0d", expCount),
              {bubbleOutOdd, bubbleOutEven},
              expectedPair(expCount, bootActive, pageActive, moduleEnable));
endtask

task automatic resetStateTest();
    checkBit("loadBootloader", loadBootloader, 1'b1);
    checkBit("loadPage", loadPage, 1'b1);
    checkPair("bubbleOutOdd,bubbleOutEven", {bubbleOutOdd, bubbleOutEven}, 2'b11);
    moduleEnable = 1'b1;
    @(negedge bubble_buffer_write_clock);
    checkPair("bubbleOutOdd,bubbleOutEven", {bubbleOutOdd, bubbleOutEven}, 2'b00);
    moduleEnable = 1'b0;
    @(negedge bubble_buffer_write_clock);
endtask

task automatic apbPortTest();
    apbWrite(291, 2'b01);
    apbWrite(292, 2'b10);
    apbRead(291, 2'b10);
    checkBit("pSlvErr", pSlvErr, 1'b0); // Idle after the failed read
    apbWrite(293, 2'b11);
endtask

task automatic accessFsmTest();
    setAccess(bubblePkg::bootloaderAccess);
    checkBit("loadBootloader", loadBootloader, 1'b0);
    checkBit("loadPage", loadPage, 1'b1);
    setAccess(bubblePkg::normalStandby); // Coil high
    checkBit("loadBootloader", loadBootloader, 1'b1);
    checkBit("loadPage", loadPage, 1'b1);
    setAccess(bubblePkg::normalAccess);  // Coil low
    checkBit("loadPage", loadPage, 1'b1);
    setAccess(bubblePkg::pageLatch);
    checkBit("loadBootloader", loadBootloader, 1'b1);
    checkBit("loadPage", loadPage, 1'b0);
    // Coil high with latch low straight out of page latch is refused
    setAccess(bubblePkg::normalStandby);
    checkBit("loadPage", loadPage, 1'b0);
    setAccess(bubblePkg::normalAccess);
    checkBit("loadPage", loadPage, 1'b0);
    setAccess(bubblePkg::bootloaderAccess); // Refused from normal access
    checkBit("loadBootloader", loadBootloader, 1'b1);
    checkBit("loadPage", loadPage, 1'b0);
    setAccess(bubblePkg::normalAccess);
    setAccess(bubblePkg::normalStandby);
    checkBit("loadBootloader", loadBootloader, 1'b1);
    checkBit("loadPage", loadPage, 1'b1);
endtask

task automatic pageTransferTest();
    fillRandom(PageWords);
    apbRead(7, ~modelMem[7]); // Word 7 is checked in the window below
    setAccess(bubblePkg::normalAccess);
    setAccess(bubblePkg::pageLatch);
    checkBit("loadPage", loadPage, 1'b0);
    pageActive = 1'b1;
    expCount   = CountSpan - 1;
    while (expCount != PageLastCount)
        tickAndCheck();
    setAccess(bubblePkg::normalAccess);
    setAccess(bubblePkg::normalStandby);
    pageActive = 1'b0;
    checkBit("loadPage", loadPage, 1'b1);
    checkPair("bubbleOutOdd,bubbleOutEven", {bubbleOutOdd, bubbleOutEven}, 2'b11);
endtask

task automatic bootTransferTest();
    fillRandom(BootWords);
    setAccess(bubblePkg::bootloaderAccess);
    checkBit("loadBootloader", loadBootloader, 1'b0);
    bootActive = 1'b1;
    expCount   = CountSpan - 1;
    while (expCount != BootLastCount) // Covers preamble, data, tail and idle
        tickAndCheck();
    setAccess(bubblePkg::normalStandby);
    bootActive = 1'b0;
    checkBit("loadBootloader", loadBootloader, 1'b1);
    checkPair("bubbleOutOdd,bubbleOutEven", {bubbleOutOdd, bubbleOutEven}, 2'b11);
endtask

task automatic moduleDisableTest();
    setAccess(bubblePkg::normalAccess);
    setAccess(bubblePkg::pageLatch);
    pageActive = 1'b1;
    expCount   = CountSpan - 1;
    while (expCount != DisableCount - 4)
        tickAndCheck();
    moduleEnable = 1'b1;
    @(negedge bubble_buffer_write_clock);
    checkPair("bubbleOutOdd,bubbleOutEven", {bubbleOutOdd, bubbleOutEven}, 2'b00);
    repeat (2) tickAndCheck(); // Still forced low
    moduleEnable = 1'b0;
    @(negedge bubble_buffer_write_clock);
    checkPair("bubbleOutOdd,bubbleOutEven", {bubbleOutOdd, bubbleOutEven},
              expectedPair(expCount, bootActive, pageActive, 1'b0));
    while (expCount != DisableCount)
        tickAndCheck();
    setAccess(bubblePkg::normalAccess);
    setAccess(bubblePkg::normalStandby);
    pageActive = 1'b0;
    checkBit("loadPage", loadPage, 1'b1);
endtask

//--- test/bubbleInterfaceTb.sv
`timescale 1ns/100ps

module bubbleInterfaceTb;

    localparam int ClockPeriod   = 8;
    localparam int ResetCycles   = 5;
    localparam int PageStart     = bubblePkg::DefaultPageStart;
    localparam int BootStart     = bubblePkg::DefaultBootStart;
    localparam int PageWindow    = bubblePkg::DefaultPageWindow;
    localparam int BootWindow    = bubblePkg::DefaultBootWindow;
    localparam int BootTail      = bubblePkg::DefaultBootTail;
    localparam int PageWords     = PageWindow / 2;
    localparam int BootWords     = BootWindow / 2;
    localparam int CountSpan     = 1 << bubblePkg::CountWidth;
    localparam int PageLastCount = 1300;
    localparam int BootLastCount = 9300;
    localparam int DisableCount  = PageStart + 110;

    // Four clocks per tick plus two per APB write, with margin
    localparam int TotalTicks  = PageLastCount + BootLastCount + DisableCount + 3;
    localparam int WriteClocks = 2 * (PageWords + BootWords + 8);
    localparam int WatchdogNs  = (4 * TotalTicks + WriteClocks + 100) * ClockPeriod + 120000;

    logic                            bubble_buffer_write_clock;
    logic                            arstN;
    logic                            pSel;
    logic                            pEnable;
    logic                            pWrite;
    logic [bubblePkg::AddrWidth-1:0] pAddr;
    logic [1:0]                      pWData;
    logic                            pReady;
    logic                            pSlvErr;
    logic                            pageSelect;
    logic                            coilEnable;
    logic                            positionLatch;
    logic                            dataOutTick;
    logic                            moduleEnable;
    logic                            loadBootloader;
    logic                            loadPage;
    logic                            bubbleOutOdd;
    logic                            bubbleOutEven;

    logic [1:0] modelMem [0:(1 << bubblePkg::AddrWidth)-1]; // Words written over APB
    int         seed = 39634;
    int         errorCount = 0;
    int         expCount;    // Tick count the DUT should hold
    logic       pageActive;
    logic       bootActive;

    bubbleInterface dut0
    (
        .bubble_buffer_write_clock (bubble_buffer_write_clock),
        .arstN                     (arstN),
        .pSel                      (pSel),
        .pEnable                   (pEnable),
        .pWrite                    (pWrite),
        .pAddr                     (pAddr),
        .pWData                    (pWData),
        .pReady                    (pReady),
        .pSlvErr                   (pSlvErr),
        .pageSelect                (pageSelect),
        .coilEnable                (coilEnable),
        .positionLatch             (positionLatch),
        .dataOutTick               (dataOutTick),
        .moduleEnable              (moduleEnable),
        .loadBootloader            (loadBootloader),
        .loadPage                  (loadPage),
        .bubbleOutOdd              (bubbleOutOdd),
        .bubbleOutEven             (bubbleOutEven)
    );

    task automatic checkBit(input string name, input logic got, input logic expected);
        if (got !== expected)
        begin
            errorCount++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected);
            $display("TEST FAIL");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    task automatic checkPair(input string name, input logic [1:0] got, input logic [1:0] expected);
        if (got !== expected)
        begin
            errorCount++;
            $display("CHECK FAILED %s got 0x%h expected 0x%h", name, got, expected);
            $display("TEST FAIL");
            $fatal(1, "Stopped at first mismatch");
        end
    endtask

    `include "bubbleInterfaceTests.svh"

    initial
    begin
        bubble_buffer_write_clock = 1'b0;
        forever #(ClockPeriod / 2) bubble_buffer_write_clock = ~bubble_buffer_write_clock;
    end

    initial
    begin
        #(WatchdogNs);
        $display("Watchdog expired before the tests finished");
        $display("TEST FAIL");
        $fatal(1, "Timeout");
    end

    initial
    begin
        arstN         = 1'b0;
        pSel          = 1'b0;
        pEnable       = 1'b0;
        pWrite        = 1'b0;
        pAddr         = '0;
        pWData        = 2'b00;
        pageSelect    = 1'b0;
        coilEnable    = 1'b1; // Initial standby code
        positionLatch = 1'b0;
        dataOutTick   = 1'b0;
        moduleEnable  = 1'b0;
        pageActive    = 1'b0;
        bootActive    = 1'b0;
        expCount      = CountSpan - 1;
        repeat (ResetCycles) @(negedge bubble_buffer_write_clock);
        arstN = 1'b1;
        @(negedge bubble_buffer_write_clock);
        resetStateTest();
        apbPortTest();
        accessFsmTest();
        pageTransferTest();
        bootTransferTest();
        moduleDisableTest();
        if (errorCount == 0)
        begin
            $display("TEST PASS");
            $finish;
        end
        else
        begin
            $display("TEST FAIL");
            $fatal(1, "Checks failed");
        end
    end

endmodule

//--- bubbleInterface.f
+incdir+test
rtl/bubblePkg.sv
rtl/bubbleAccessFsm.sv
rtl/bubbleBuffer.sv
rtl/bubbleOutSequencer.sv
rtl/bubbleOutputMux.sv
rtl/bubbleInterface.sv
test/bubbleInterfaceTb.sv

//--- run.sh
#!/usr/bin/env bash
# Build the bubbleInterface testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
LOG=sim.log
verilator --binary --timing -Wno-fatal -f bubbleInterface.f \
    --top-module bubbleInterfaceTb -o bubbleInterfaceSim > "$LOG" 2>&1 \
    && ./obj_dir/bubbleInterfaceSim >> "$LOG" 2>&1 \
    || echo "TEST FAIL" >> "$LOG"
cat "$LOG"
if grep -q "TEST FAIL" "$LOG"; then
    exit 1
fi
exit 0
